// File: Bender.yml
package:
  name: pixel_loader

sources:
  - source/pix_geom_pkg.sv
  - source/pix_stream_pkg.sv
  - source/column_packer.sv
  - source/edge_ram.sv
  - source/column_window.sv
  - source/pixel_loader.sv
  - target: test
    files:
      - tests/pixel_loader_assertions.sv
      - tests/tb_pixel_loader.sv

// File: files.f
source/pix_geom_pkg.sv
source/pix_stream_pkg.sv
source/column_packer.sv
source/edge_ram.sv
source/column_window.sv
source/pixel_loader.sv
tests/pixel_loader_assertions.sv
tests/tb_pixel_loader.sv

// File: source/column_packer.sv
`timescale 1ns/1ns

module column_packer #(
  parameter int ROWS = pix_geom_pkg::ROWS_DEF,
  parameter int EDGE = pix_geom_pkg::KH_MAX_DEF / 2
) (
  input  logic                                 aclk,
  input  logic                                 aresetn,
  input  logic                                 i_en,
  input  pix_geom_pkg::kh2_t                   i_kh2,
  input  logic                                 i_s_valid,
  output logic                                 o_s_ready,
  input  pix_geom_pkg::word_t                  i_s_data,
  input  logic                                 i_s_last,
  output logic                                 o_col_valid,
  input  logic                                 i_col_ready,
  output pix_geom_pkg::word_t [ROWS+EDGE-1:0]  o_col_data,
  output logic                                 o_col_last
);

  localparam int N  = ROWS + EDGE;
  localparam int CW = $clog2(N + 1);

  logic [CW-1:0] cnt;
  logic [CW-1:0] cnt_end;
  logic          take;
  logic          accept;

  // No bottom halo words without a kernel height
  assign cnt_end = (i_kh2 == '0) ? CW'(ROWS - 1) : CW'(N - 1);

  assign take      = o_col_valid && i_col_ready;

  // Next frame waits for its header after the frame's last column
  assign o_s_ready = i_en && (!o_col_valid || (i_col_ready && !o_col_last));
  assign accept    = i_s_valid && o_s_ready;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      cnt         <= '0;
      o_col_valid <= 1'b0;
    end else begin
      if (accept) begin
        cnt <= (cnt == cnt_end) ? '0 : cnt + 1'b1;
      end
      if (accept && cnt == cnt_end) begin
        o_col_valid <= 1'b1;
      end else if (take) begin
        o_col_valid <= 1'b0;
      end
    end
  end

  // First word of a column clears the unused slots
  always_ff @(posedge aclk) begin
    if (accept) begin
      if (cnt == '0) begin
        o_col_data <= '0;
      end
      o_col_data[cnt] <= i_s_data;
      if (cnt == cnt_end) begin
        o_col_last <= i_s_last;
      end
    end
  end

endmodule

// File: source/column_window.sv
`timescale 1ns/1ns

module column_window #(
  parameter  int ROWS   = pix_geom_pkg::ROWS_DEF,
  parameter  int KH_MAX = pix_geom_pkg::KH_MAX_DEF,
  localparam int EDGE   = KH_MAX / 2
) (
  input  logic                                 aclk,
  input  logic                                 aresetn,
  input  logic                                 i_s_valid,
  input  pix_stream_pkg::frame_hdr_t           i_s_user,
  output logic                                 o_s_en,
  output pix_geom_pkg::kh2_t                   o_kh2,
  input  logic                                 i_col_valid,
  output logic                                 o_col_ready,
  input  pix_geom_pkg::word_t [ROWS+EDGE-1:0]  i_col_data,
  input  logic                                 i_col_last,
  output logic                                 o_ram_en,
  output logic                                 o_ram_we,
  output pix_geom_pkg::ram_addr_t              o_ram_addr,
  output pix_geom_pkg::word_t [EDGE-1:0]       o_ram_wdata,
  input  pix_geom_pkg::word_t [EDGE-1:0]       i_ram_rdata,
  output logic                                 o_m_valid,
  input  logic                                 i_m_ready,
  output pix_geom_pkg::word_t [ROWS-1:0]       o_m_data,
  output logic                                 o_m_last
);

  import pix_geom_pkg::*;
  import pix_stream_pkg::*;

  localparam int SR_N = ROWS + 2 * EDGE;

  typedef enum logic [1:0] {IDLE, RUN, DRAIN} state_t;

  state_t                 state;
  frame_hdr_t             hdr;
  kh2_t                   kh2;
  ci_t                    ci_cnt;
  w_t                     w_cnt;
  blk_t                   blk_cnt;
  ram_addr_t              addr_cnt;
  col_ctl_t               ctl;
  col_ctl_t               ctl_r;
  logic                   take;
  logic                   load;
  logic                   out_fire;
  logic                   out_done;
  logic                   out_free;
  logic                   s1_free;
  logic                   s1_valid;
  word_t [ROWS+EDGE-1:0]  col_r;
  logic                   last_r;
  logic                   rd;
  logic                   rd_pend;
  logic                   wr_pend;
  word_t [EDGE-1:0]       halo_hold;
  word_t [EDGE-1:0]       halo_cur;
  word_t [EDGE-1:0]       halo_top;
  word_t [SR_N-1:0]       sr;
  logic [$bits(kh2_t):0]  step;
  logic [$bits(kh2_t):0]  step_end;
  logic                   last_q;

  // Header is read in IDLE while the input is still held off
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (i_s_valid) begin
            state <= RUN;
          end
        end
        RUN: begin
          if (take && i_col_last) begin
            state <= DRAIN;
          end
        end
        DRAIN: begin
          if (out_fire && o_m_last) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      hdr <= '0;
    end else if (state == IDLE && i_s_valid) begin
      hdr <= i_s_user;
    end
  end

  // Heights beyond KH_MAX fall back to a single row
  assign kh2    = (hdr.kh2 > EDGE) ? '0 : hdr.kh2;
  assign o_kh2  = kh2;
  assign o_s_en = (state == RUN);

  assign ctl.first_blk = (blk_cnt == '0);
  assign ctl.last_blk  = (blk_cnt == hdr.blk);
  assign ctl.last_col  = (ci_cnt == hdr.ci) && (w_cnt == hdr.w);
  assign ctl.ram_addr  = addr_cnt;

  // Channel, width and block counters step per taken column
  always_ff @(posedge aclk) begin
    if (!aresetn || state == IDLE) begin
      ci_cnt   <= '0;
      w_cnt    <= '0;
      blk_cnt  <= '0;
      addr_cnt <= '0;
    end else if (take) begin
      if (ci_cnt == hdr.ci) begin
        ci_cnt <= '0;
        if (w_cnt == hdr.w) begin
          w_cnt   <= '0;
          blk_cnt <= ctl.last_blk ? '0 : blk_cnt + 1'b1;
        end else begin
          w_cnt <= w_cnt + 1'b1;
        end
      end else begin
        ci_cnt <= ci_cnt + 1'b1;
      end
      addr_cnt <= ctl.last_col ? '0 : addr_cnt + 1'b1;
    end
  end

  assign out_fire = o_m_valid && i_m_ready;
  assign step_end = {kh2, 1'b0};
  assign out_done = out_fire && (step == step_end);
  assign out_free = !o_m_valid || out_done;
  assign load     = s1_valid && out_free;
  assign s1_free  = !s1_valid || load;

  // The cycle after a take is left to the halo write
  assign o_col_ready = (state == RUN) && s1_free && !wr_pend;
  assign take        = i_col_valid && o_col_ready;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      s1_valid <= 1'b0;
    end else if (take) begin
      s1_valid <= 1'b1;
    end else if (load) begin
      s1_valid <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (take) begin
      col_r  <= i_col_data;
      ctl_r  <= ctl;
      last_r <= i_col_last;
    end
  end

  // Top halo read on take, bottom rows written back next cycle
  assign rd = take && (kh2 != '0) && !ctl.first_blk;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
    end else begin
      rd_pend <= rd;
      wr_pend <= take && (kh2 != '0) && !ctl.last_blk;
    end
  end

  assign o_ram_en    = rd || wr_pend;
  assign o_ram_we    = wr_pend;
  assign o_ram_addr  = wr_pend ? ctl_r.ram_addr : ctl.ram_addr;
  assign o_ram_wdata = col_r[ROWS-1 -: EDGE];

  // Read word survives the following write and any output stall
  assign halo_cur = rd_pend ? i_ram_rdata : halo_hold;
  assign halo_top = ctl_r.first_blk ? '0 : halo_cur;

  always_ff @(posedge aclk) begin
    halo_hold <= halo_cur;
  end

  always_ff @(posedge aclk) begin
    if (load) begin
      sr <= {col_r, halo_top};
    end else if (out_fire) begin
      sr <= {word_t'(0), sr[SR_N-1:1]};
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      o_m_valid <= 1'b0;
      step      <= '0;
      last_q    <= 1'b0;
    end else if (load) begin
      o_m_valid <= 1'b1;
      step      <= '0;
      last_q    <= last_r;
    end else if (out_done) begin
      o_m_valid <= 1'b0;
    end else if (out_fire) begin
      step <= step + 1'b1;
    end
  end

  assign o_m_last = o_m_valid && last_q && (step == step_end);

  // Window starts kh2 rows above the block
  always_comb begin
    for (int r = 0; r < ROWS; r++) begin
      o_m_data[r] = sr[r + EDGE - int'(kh2)];
    end
  end

endmodule

// File: source/edge_ram.sv
`timescale 1ns/1ns

module edge_ram #(
  parameter int EDGE  = pix_geom_pkg::KH_MAX_DEF / 2,
  parameter int DEPTH = pix_geom_pkg::CI_MAX_DEF * pix_geom_pkg::W_MAX_DEF
) (
  input  logic                            aclk,
  input  logic                            i_en,
  input  logic                            i_we,
  input  pix_geom_pkg::ram_addr_t         i_addr,
  input  pix_geom_pkg::word_t [EDGE-1:0]  i_wdata,
  output pix_geom_pkg::word_t [EDGE-1:0]  o_rdata
);

  import pix_geom_pkg::*;

  word_t [EDGE-1:0] mem [DEPTH];

  // Output keeps its value during a write
  always_ff @(posedge aclk) begin
    if (i_en) begin
      if (i_we) begin
        mem[i_addr] <= i_wdata;
      end else begin
        o_rdata <= mem[i_addr];
      end
    end
  end

endmodule

// File: source/pix_geom_pkg.sv
package pix_geom_pkg;

  // Default geometry of the loader
  localparam int ROWS_DEF    = 4;
  localparam int KH_MAX_DEF  = 3;
  localparam int CI_MAX_DEF  = 4;
  localparam int W_MAX_DEF   = 8;
  localparam int BLK_MAX_DEF = 4;

  typedef logic [7:0] word_t;

  // Kernel half-height, kernel height is 2*kh2+1
  typedef logic [1:0] kh2_t;

  // Header counts, each holds the value minus one
  typedef logic [2:0] ci_t;
  typedef logic [3:0] w_t;
  typedef logic [2:0] blk_t;

  // Column position within a block, channel fastest
  typedef logic [4:0] ram_addr_t;

endpackage

// File: source/pix_stream_pkg.sv
package pix_stream_pkg;

  // Frame header on the user field of the first word
  typedef struct packed {
    pix_geom_pkg::kh2_t kh2;
    pix_geom_pkg::ci_t  ci;
    pix_geom_pkg::w_t   w;
    pix_geom_pkg::blk_t blk;
  } frame_hdr_t;

  // Where a column sits in the frame
  typedef struct packed {
    logic                    first_blk;
    logic                    last_blk;
    logic                    last_col;
    pix_geom_pkg::ram_addr_t ram_addr;
  } col_ctl_t;

endpackage

// File: source/pixel_loader.sv
`timescale 1ns/1ns

module pixel_loader #(
  parameter int ROWS    = pix_geom_pkg::ROWS_DEF,
  parameter int KH_MAX  = pix_geom_pkg::KH_MAX_DEF,
  parameter int CI_MAX  = pix_geom_pkg::CI_MAX_DEF,
  parameter int W_MAX   = pix_geom_pkg::W_MAX_DEF,
  parameter int BLK_MAX = pix_geom_pkg::BLK_MAX_DEF
) (
  input  logic                            aclk,
  input  logic                            aresetn,
  input  logic                            i_s_valid,
  output logic                            o_s_ready,
  input  pix_geom_pkg::word_t             i_s_data,
  input  logic                            i_s_last,
  input  pix_stream_pkg::frame_hdr_t      i_s_user,
  output logic                            o_m_valid,
  input  logic                            i_m_ready,
  output pix_geom_pkg::word_t [ROWS-1:0]  o_m_data,
  output logic                            o_m_last
);

  import pix_geom_pkg::*;

  localparam int EDGE  = KH_MAX / 2;
  localparam int DEPTH = CI_MAX * W_MAX;

  logic                   s_en;
  kh2_t                   kh2;
  logic                   col_valid;
  logic                   col_ready;
  logic                   col_last;
  word_t [ROWS+EDGE-1:0]  col_data;
  logic                   ram_en;
  logic                   ram_we;
  ram_addr_t              ram_addr;
  word_t [EDGE-1:0]       ram_wdata;
  word_t [EDGE-1:0]       ram_rdata;

  // Geometry must fit the header fields and RAM address
  if (CI_MAX > 2 ** $bits(ci_t) || W_MAX > 2 ** $bits(w_t) ||
      BLK_MAX > 2 ** $bits(blk_t) || DEPTH > 2 ** $bits(ram_addr_t)) begin : g_bounds
    $error("pixel_loader geometry exceeds header field widths");
  end

  column_packer #(
    .ROWS (ROWS),
    .EDGE (EDGE)
  ) u_packer (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .i_en        (s_en),
    .i_kh2       (kh2),
    .i_s_valid   (i_s_valid),
    .o_s_ready   (o_s_ready),
    .i_s_data    (i_s_data),
    .i_s_last    (i_s_last),
    .o_col_valid (col_valid),
    .i_col_ready (col_ready),
    .o_col_data  (col_data),
    .o_col_last  (col_last)
  );

  column_window #(
    .ROWS   (ROWS),
    .KH_MAX (KH_MAX)
  ) u_window (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .i_s_valid   (i_s_valid),
    .i_s_user    (i_s_user),
    .o_s_en      (s_en),
    .o_kh2       (kh2),
    .i_col_valid (col_valid),
    .o_col_ready (col_ready),
    .i_col_data  (col_data),
    .i_col_last  (col_last),
    .o_ram_en    (ram_en),
    .o_ram_we    (ram_we),
    .o_ram_addr  (ram_addr),
    .o_ram_wdata (ram_wdata),
    .i_ram_rdata (ram_rdata),
    .o_m_valid   (o_m_valid),
    .i_m_ready   (i_m_ready),
    .o_m_data    (o_m_data),
    .o_m_last    (o_m_last)
  );

  edge_ram #(
    .EDGE  (EDGE),
    .DEPTH (DEPTH)
  ) u_edge_ram (
    .aclk    (aclk),
    .i_en    (ram_en),
    .i_we    (ram_we),
    .i_addr  (ram_addr),
    .i_wdata (ram_wdata),
    .o_rdata (ram_rdata)
  );

endmodule

// File: tests/pixel_loader_assertions.sv
`timescale 1ns/1ns

module pixel_loader_assertions #(
  parameter int ROWS = pix_geom_pkg::ROWS_DEF
) (
  input logic                            aclk,
  input logic                            aresetn,
  input logic                            i_s_valid,
  input logic                            i_s_ready,
  input logic                            i_s_last,
  input logic                            i_col_valid,
  input logic                            i_m_valid,
  input logic                            i_m_ready,
  input pix_geom_pkg::word_t [ROWS-1:0]  i_m_data,
  input logic                            i_m_last
);

  int unsigned fail_count = 0;
  logic        hdr_wait;

  // High until the first word of a frame is taken
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      hdr_wait <= 1'b1;
    end else if (i_s_valid && i_s_ready) begin
      hdr_wait <= i_s_last;
    end
  end

  // Handshake outputs idle right after a reset cycle
  reset_quiet: assert property (
    @(posedge aclk) !aresetn |=> !i_s_ready && !i_m_valid && !i_m_last && !i_col_valid
  ) else begin
    fail_count++;
    $error("handshake outputs not idle after reset");
  end

  // First word of a frame only after a header cycle with input held off
  header_hold_off: assert property (
    @(posedge aclk) disable iff (!aresetn)
    hdr_wait && i_s_valid && i_s_ready |-> $past(i_s_valid && !i_s_ready)
  ) else begin
    fail_count++;
    $error("input ready high while the header is taken");
  end

  stall_stable: assert property (
    @(posedge aclk) disable iff (!aresetn)
    i_m_valid && !i_m_ready |=> i_m_valid && $stable(i_m_data) && $stable(i_m_last)
  ) else begin
    fail_count++;
    $error("output beat changed while stalled");
  end

endmodule

bind pixel_loader pixel_loader_assertions #(
  .ROWS (ROWS)
) u_assertions (
  .aclk        (aclk),
  .aresetn     (aresetn),
  .i_s_valid   (i_s_valid),
  .i_s_ready   (o_s_ready),
  .i_s_last    (i_s_last),
  .i_col_valid (col_valid),
  .i_m_valid   (o_m_valid),
  .i_m_ready   (i_m_ready),
  .i_m_data    (o_m_data),
  .i_m_last    (o_m_last)
);

// File: tests/tb_pixel_loader.sv
`timescale 1ns/1ns

module tb_pixel_loader;

  import pix_geom_pkg::*;
  import pix_stream_pkg::*;

  localparam int ROWS     = ROWS_DEF;
  localparam int EDGE     = KH_MAX_DEF / 2;
  localparam int DEPTH    = CI_MAX_DEF * W_MAX_DEF;
  localparam int N_FRAMES = 6;

  typedef word_t [ROWS-1:0] beat_t;

  logic        aclk;
  logic        aresetn;
  logic        i_s_valid;
  logic        o_s_ready;
  word_t       i_s_data;
  logic        i_s_last;
  frame_hdr_t  i_s_user;
  logic        o_m_valid;
  logic        i_m_ready;
  beat_t       o_m_data;
  logic        o_m_last;

  logic [31:0] src_lfsr;
  logic [31:0] snk_lfsr;
  frame_hdr_t  hdr_list [N_FRAMES];
  string       name_list [N_FRAMES];
  word_t       block_rows [DEPTH][ROWS];
  word_t       src_words [$];
  beat_t       exp_data [$];
  logic        exp_last [$];
  int          exp_frame [$];
  int          cycle_cnt = 0;
  int          cycle_limit;

  pixel_loader dut (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .i_s_valid (i_s_valid),
    .o_s_ready (o_s_ready),
    .i_s_data  (i_s_data),
    .i_s_last  (i_s_last),
    .i_s_user  (i_s_user),
    .o_m_valid (o_m_valid),
    .i_m_ready (i_m_ready),
    .o_m_data  (o_m_data),
    .o_m_last  (o_m_last)
  );

  initial begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;
  end

  // Galois LFSR, taps 32 22 2 1, one step per bit
  task automatic draw_bits(inout logic [31:0] state, input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits  = {bits[30:0], state[0]};
      state = state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    end
  endtask

  task automatic next_cycle();
    @(posedge aclk);
    #1;
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1, "run stopped at first error");
  endtask

  // Words in plus beats out for one frame
  function automatic int frame_cost(input frame_hdr_t h);
    int cols;
    cols = (int'(h.blk) + 1) * (int'(h.w) + 1) * (int'(h.ci) + 1);
    return cols * (ROWS + ((h.kh2 != '0) ? EDGE : 0)) + cols * (2 * int'(h.kh2) + 1);
  endfunction

  // Reference model, builds the words to send and the beats to expect
  task automatic build_frame(input int f);
    frame_hdr_t  hdr;
    int          kh2;
    int          n_words;
    int          addr;
    logic        last_col;
    logic [31:0] rnd;
    word_t       v [ROWS+2*EDGE];
    beat_t       beat;
    hdr     = hdr_list[f];
    kh2     = int'(hdr.kh2);
    n_words = (kh2 == 0) ? ROWS : ROWS + EDGE;
    src_words.delete();
    for (int b = 0; b <= int'(hdr.blk); b++) begin
      for (int w = 0; w <= int'(hdr.w); w++) begin
        for (int c = 0; c <= int'(hdr.ci); c++) begin
          addr     = w * (int'(hdr.ci) + 1) + c;
          last_col = (b == int'(hdr.blk)) && (w == int'(hdr.w)) && (c == int'(hdr.ci));
          // Top halo from the block above
          for (int k = 0; k < EDGE; k++) begin
            v[k] = (b == 0) ? '0 : block_rows[addr][ROWS-EDGE+k];
          end
          for (int k = 0; k < ROWS + EDGE; k++) begin
            v[EDGE+k] = '0;
            if (k < n_words) begin
              draw_bits(src_lfsr, 8, rnd);
              v[EDGE+k] = rnd[7:0];
              src_words.push_back(rnd[7:0]);
            end
          end
          for (int k = 0; k < ROWS; k++) begin
            block_rows[addr][k] = v[EDGE+k];
          end
          for (int j = 0; j <= 2 * kh2; j++) begin
            for (int r = 0; r < ROWS; r++) begin
              beat[r] = v[r + EDGE - kh2 + j];
            end
            exp_data.push_back(beat);
            exp_last.push_back(last_col && (j == 2 * kh2));
            exp_frame.push_back(f);
          end
        end
      end
    end
  endtask

  task automatic send_frame(input frame_hdr_t hdr);
    logic [31:0] gap;
    for (int k = 0; k < src_words.size(); k++) begin
      draw_bits(src_lfsr, 2, gap);
      while (gap[1:0] == 2'b00) begin
        i_s_valid = 1'b0;
        next_cycle();
        draw_bits(src_lfsr, 2, gap);
      end
      i_s_valid = 1'b1;
      i_s_data  = src_words[k];
      i_s_last  = (k == src_words.size() - 1);
      i_s_user  = hdr;
      @(negedge aclk);
      while (!o_s_ready) begin
        @(negedge aclk);
      end
      next_cycle();
    end
  endtask

  task automatic check_beat();
    beat_t exp;
    logic  exp_l;
    string name;
    if (exp_data.size() == 0) begin
      report_failure("output beat accepted while no beat was expected");
    end else begin
      exp   = exp_data.pop_front();
      exp_l = exp_last.pop_front();
      name  = name_list[exp_frame.pop_front()];
      assert (o_m_data === exp) else begin
        report_failure($sformatf("MISMATCH %s o_m_data expected %h actual %h",
                                 name, exp, o_m_data));
      end
      assert (o_m_last === exp_l) else begin
        report_failure($sformatf("MISMATCH %s o_m_last expected %b actual %b",
                                 name, exp_l, o_m_last));
      end
    end
  endtask

  always @(posedge aclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      report_failure($sformatf("timeout after %0d cycles, %0d beats never arrived",
                               cycle_cnt, exp_data.size()));
    end
  end

  always @(negedge aclk) begin
    if (dut.u_assertions.fail_count != 0) begin
      report_failure("a protocol assertion on the DUT failed");
    end
  end

  // Sink with random backpressure
  initial begin : sink
    logic [31:0] bits;
    wait (aresetn === 1'b1);
    forever begin
      next_cycle();
      draw_bits(snk_lfsr, 2, bits);
      i_m_ready = (bits[1:0] != 2'b00);
      @(negedge aclk);
      if (o_m_valid && i_m_ready) begin
        check_beat();
      end
    end
  end

  initial begin : main
    aresetn   = 1'b0;
    i_s_valid = 1'b0;
    i_s_data  = '0;
    i_s_last  = 1'b0;
    i_s_user  = '0;
    i_m_ready = 1'b0;
    src_lfsr  = 32'h783d;
    snk_lfsr  = 32'h783d;
    hdr_list[0]  = '{kh2: 2'd0, ci: 3'd1, w: 4'd2, blk: 3'd1};
    name_list[0] = "kh0_two_blocks";
    hdr_list[1]  = '{kh2: 2'd1, ci: 3'd0, w: 4'd3, blk: 3'd0};
    name_list[1] = "kh1_first_block";
    hdr_list[2]  = '{kh2: 2'd1, ci: 3'd2, w: 4'd3, blk: 3'd2};
    name_list[2] = "kh1_halo_three_blocks";
    hdr_list[3]  = '{kh2: 2'd1, ci: 3'd3, w: 4'd7, blk: 3'd3};
    name_list[3] = "kh1_full_size";
    hdr_list[4]  = '{kh2: 2'd0, ci: 3'd0, w: 4'd0, blk: 3'd0};
    name_list[4] = "kh0_single_column";
    hdr_list[5]  = '{kh2: 2'd1, ci: 3'd0, w: 4'd0, blk: 3'd3};
    name_list[5] = "kh1_column_per_block";
    cycle_limit = 10;
    for (int f = 0; f < N_FRAMES; f++) begin
      cycle_limit += 4 * frame_cost(hdr_list[f]) + 20;
    end
    repeat (10) @(posedge aclk);
    #1;
    aresetn = 1'b1;
    // Frames back to back, header changes each time
    for (int f = 0; f < N_FRAMES; f++) begin
      build_frame(f);
      send_frame(hdr_list[f]);
    end
    i_s_valid = 1'b0;
    i_s_last  = 1'b0;
    while (exp_data.size() != 0) begin
      next_cycle();
    end
    repeat (4) next_cycle();
    if (dut.u_assertions.fail_count == 0 && !o_m_valid) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      report_failure("output still busy or an assertion failed at the end of the run");
    end
  end

endmodule
